//--- Bender.yml
package:
  name: alu_cluster

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/alu_pkg.sv
      - hw/alu_lane.sv
      - hw/cmd_dispatch.sv
      - hw/result_collect.sv
      - hw/axil_regs.sv
      - hw/alu_cluster_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_alu_cluster.sv

//--- bench/tb_alu_cluster.sv
/*
 * ALU cluster testbench
 * directed tests over AXI4-Lite, with a per-lane reference model
 * of results and flags and a watchdog
 */
`timescale 1ns/100ps
`include "alu_config.svh"

module tb_alu_cluster;
    import alu_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int RST_CYCLES  = 4;
    localparam int HS_TIMEOUT  = 32;   // cycles per handshake
    localparam int CMD_LATENCY = 4;    // command handshake to bvalid
    localparam int NL          = `ALU_NUM_LANES;
    localparam int N_EDGE      = 4;
    localparam int N_RAND      = 3;
    localparam int N_LOGIC     = 2;
    localparam int N_EXT       = 3;
    localparam int N_SCAN      = 4;
    localparam int N_CMDS      = NL + 6*3*(N_EDGE+N_RAND) + 5*2*3*N_LOGIC + 3*2*N_EXT
                                 + 2*2*N_SCAN + 10 + 1 + 4;
    localparam longint WATCHDOG_NS = longint'(N_CMDS*20 + 100) * CLK_PERIOD;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic                     clk, rst;
    logic [`ALU_ADDR_W-1:0]   s_awaddr, s_araddr;
    logic                     s_awvalid, s_awready, s_wvalid, s_wready;
    logic [`ALU_DATA_W-1:0]   s_wdata, s_rdata;
    logic [`ALU_DATA_W/8-1:0] s_wstrb;
    logic [1:0]               s_bresp, s_rresp;
    logic                     s_bvalid, s_bready, s_arvalid, s_arready, s_rvalid, s_rready;

    int          errors, checks, timeouts;
    logic [31:0] rng_state;
    logic [31:0] last_result;
    logic [31:0] ref_result [NL];   // model copy of each lane context
    alu_flags_t  ref_flags [NL];

    alu_cluster_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic check_result(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flags(input string name, input alu_flags_t got, input alu_flags_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_lane(input string name, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // called just after a drive point, returns after the B handshake
    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                              output logic [1:0] resp, output int lat);
        logic hs;
        int   n;
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = 4'hF;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        s_bready  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            hs = s_awready && s_wready;
            n++;
            @(posedge clk);
        end while (!hs && n < HS_TIMEOUT);
        #(DRIVE_DLY);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        resp = 2'bxx;
        lat  = 0;
        if (!hs) begin
            timeouts++;
            $display("write to %h was never accepted", addr);
            return;
        end
        do begin
            @(negedge clk);
            lat++;
        end while (!s_bvalid && lat < HS_TIMEOUT);
        if (!s_bvalid) begin
            timeouts++;
            $display("no write response arrived for %h", addr);
            return;
        end
        resp = s_bresp;
        @(posedge clk);
        #(DRIVE_DLY);
        s_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        logic hs;
        int   n;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            hs = s_arready;
            n++;
            @(posedge clk);
        end while (!hs && n < HS_TIMEOUT);
        #(DRIVE_DLY);
        s_arvalid = 1'b0;
        data = 'x;
        resp = 2'bxx;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (hs && !s_rvalid && n < HS_TIMEOUT);
        if (!hs || !s_rvalid) begin
            timeouts++;
            $display("read of %h did not complete", addr);
            return;
        end
        data = s_rdata;
        resp = s_rresp;
        @(posedge clk);
        #(DRIVE_DLY);
        s_rready = 1'b0;
    endtask

    // reference model, updates the lane's context
    task automatic model_exec(input int lane, input alu_op_e op, input alu_width_e width,
                              input logic [31:0] src, input logic [31:0] dst,
                              output logic [31:0] res, output alu_flags_t f);
        logic [31:0] mask, a, b, d;
        logic [32:0] wide;
        logic        cin, found;
        int          w, idx;
        idx = lane % NL;
        f   = ref_flags[idx];
        res = ref_result[idx];
        w    = (width == ALU_W_BYTE) ? 8 : (width == ALU_W_WORD) ? 16 : 32;
        mask = (w == 32) ? 32'hFFFF_FFFF : (32'h1 << w) - 32'h1;
        d    = '0;
        case (op)
            ALU_ADD, ALU_ADC: begin
                a    = dst & mask;
                b    = src & mask;
                cin  = (op == ALU_ADC) ? f.c : 1'b0;
                wide = {1'b0, a} + {1'b0, b} + 33'(cin);
                d    = wide[31:0] & mask;
                f.c  = wide[w];
                f.h  = (int'(a[3:0]) + int'(b[3:0]) + int'(cin)) > 15;
                f.v  = (a[w-1] == b[w-1]) && (d[w-1] != a[w-1]);
                f.n  = 1'b0;
                f.s  = d[w-1];
                f.z  = d == '0;
                res  = d;
            end
            ALU_SUB, ALU_SBC, ALU_CP, ALU_NEG: begin
                a   = (op == ALU_NEG) ? 32'd0 : dst & mask;
                b   = (op == ALU_NEG) ? dst & mask : src & mask;
                cin = (op == ALU_SBC) ? f.c : 1'b0;  // borrow in
                d   = (a - b - 32'(cin)) & mask;
                f.c = longint'(a) < longint'(b) + longint'(cin);
                f.h = int'(a[3:0]) < int'(b[3:0]) + int'(cin);
                f.v = (a[w-1] != b[w-1]) && (d[w-1] != a[w-1]);
                f.n = 1'b1;
                f.s = d[w-1];
                f.z = d == '0;
                if (op != ALU_CP)
                    res = d;
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                d   = (op == ALU_AND) ? dst & src : (op == ALU_OR) ? dst | src : dst ^ src;
                d   = d & mask;
                f.s = d[w-1];
                f.z = d == '0;
                f.h = op == ALU_AND;
                f.v = ($countones((w == 8) ? d[7:0] : d[15:0]) % 2) == 0;  // even parity
                f.n = 1'b0;
                f.c = 1'b0;
                res = d;
            end
            ALU_CPL: begin
                res = ~src & mask;
                f.h = 1'b1;
                f.n = 1'b1;
            end
            ALU_CCF: begin
                f.c = ~f.c;
                f.n = 1'b0;
            end
            ALU_MOVE: res = src & mask;
            ALU_EXTZ: res = ((w == 16) ? {24'd0, dst[7:0]} : {16'd0, dst[15:0]}) & mask;
            ALU_EXTS: begin
                d   = (w == 16) ? {16'd0, {8{dst[7]}}, dst[7:0]} : {{16{dst[15]}}, dst[15:0]};
                res = d & mask;
            end
            ALU_MIRR: begin
                for (int i = 0; i < 16; i++)
                    d[i] = dst[15-i];
                res = d & mask;
            end
            ALU_BS1F, ALU_BS1B: begin
                found = 1'b0;
                for (int i = 0; i < 16; i++) begin
                    idx = (op == ALU_BS1F) ? i : 15 - i;  // scan direction
                    if (src[idx] && !found) begin
                        d     = 32'(idx);
                        found = 1'b1;
                    end
                end
                f.v = src[15:0] == '0;
                res = d & mask;
                idx = lane % NL;
            end
            default: ;
        endcase
        ref_flags[idx]  = f;
        ref_result[idx] = res;
    endtask

    // operands and command, then RESULT and STATUS readback
    task automatic run_cmd(input int lane, input alu_op_e op, input alu_width_e width,
                           input logic use_imm, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] k);
        logic [31:0] cmd, got, status, exp_res;
        logic [1:0]  resp;
        alu_flags_t  exp_flags;
        int          lat;
        axil_write(`ALU_REG_OP0, a, resp, lat);
        check_resp("op0 bresp", resp, OKAY);
        axil_write(`ALU_REG_OP1, b, resp, lat);
        check_resp("op1 bresp", resp, OKAY);
        axil_write(`ALU_REG_IMM, k, resp, lat);
        check_resp("imm bresp", resp, OKAY);
        cmd        = '0;
        cmd[4:0]   = op;
        cmd[9:8]   = width;
        cmd[12]    = use_imm;
        cmd[17:16] = 2'(lane);
        axil_write(`ALU_REG_CMD, cmd, resp, lat);
        check_resp("cmd bresp", resp, OKAY);
        checks++;
        if (lat != CMD_LATENCY) begin
            errors++;
            $display("error at %0t: cmd bvalid latency got %0d expected %0d",
                     $time, lat, CMD_LATENCY);
        end
        model_exec(lane, op, width, use_imm ? k : b, a, exp_res, exp_flags);
        axil_read(`ALU_REG_RESULT, got, resp);
        check_resp("result rresp", resp, OKAY);
        check_result($sformatf("%s result", op.name()), got, exp_res);
        axil_read(`ALU_REG_STATUS, status, resp);
        check_resp("status rresp", resp, OKAY);
        check_flags($sformatf("%s flags", op.name()), alu_flags_t'(status[7:0]), exp_flags);
        check_lane("status lane", status[17:16], 2'(lane % NL));
        last_result = exp_res;
    endtask

    task automatic after_reset();
        logic [31:0] got;
        logic [1:0]  resp;
        axil_read(`ALU_REG_RESULT, got, resp);
        check_result("result after reset", got, 32'd0);
        axil_read(`ALU_REG_STATUS, got, resp);
        check_result("status after reset", got, 32'd0);
        for (int l = 0; l < NL; l++)
            run_cmd(l, ALU_CCF, ALU_W_LONG, 1'b0, '0, '0, '0);  // carry comes up set
    endtask

    task automatic arith_ops();
        alu_op_e     ops [6] = '{ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP, ALU_NEG};
        logic [31:0] ea [N_EDGE] = '{32'h0, 32'hFFFF_FFFF, 32'h8000_8080, 32'h7FFF_7F7F};
        logic [31:0] eb [N_EDGE] = '{32'h0, 32'h0000_0001, 32'h8000_8080, 32'h0000_0101};
        logic [31:0] a, b;
        int          n;
        n = 0;
        foreach (ops[o]) begin
            for (int wi = 0; wi < 3; wi++) begin
                for (int p = 0; p < N_EDGE + N_RAND; p++) begin
                    a = (p < N_EDGE) ? ea[p] : xorshift32();
                    b = (p < N_EDGE) ? eb[p] : xorshift32();
                    run_cmd(n % NL, ops[o], alu_width_e'(wi), 1'b0, a, b, ~b);
                    n++;
                end
            end
        end
    endtask

    task automatic logic_ops();
        alu_op_e ops [5] = '{ALU_AND, ALU_OR, ALU_XOR, ALU_CPL, ALU_MOVE};
        int      n;
        n = 0;
        foreach (ops[o]) begin
            for (int im = 0; im < 2; im++) begin
                for (int wi = 0; wi < 3; wi++) begin
                    for (int p = 0; p < N_LOGIC; p++) begin
                        run_cmd(n % NL, ops[o], alu_width_e'(wi), im[0],
                                xorshift32(), xorshift32(), xorshift32());
                        n++;
                    end
                end
            end
        end
    endtask

    task automatic ext_and_scan();
        alu_op_e     ext_ops [3] = '{ALU_EXTZ, ALU_EXTS, ALU_MIRR};
        logic [31:0] scan_src [N_SCAN] = '{32'h0, 32'h0003_0000, 32'h0000_8001, 32'h0};
        logic [31:0] v;
        foreach (ext_ops[o]) begin
            for (int wi = 1; wi < 3; wi++) begin
                for (int p = 0; p < N_EXT; p++) begin
                    v = (p == 0) ? xorshift32() : (p == 1) ? 32'h0000_8080 : 32'h0001_7F01;
                    run_cmd(p, ext_ops[o], alu_width_e'(wi), 1'b0, v, '0, '0);
                end
            end
        end
        scan_src[N_SCAN-1] = xorshift32();
        for (int o = 0; o < 2; o++) begin
            for (int wi = 1; wi < 3; wi++) begin
                for (int p = 0; p < N_SCAN; p++)
                    run_cmd(p, o ? ALU_BS1B : ALU_BS1F, alu_width_e'(wi), 1'b0,
                            '0, scan_src[p], '0);
            end
        end
    endtask

    // lane 1 starts with carry set, lane 2 with carry clear
    task automatic lane_chains();
        run_cmd(1, ALU_SUB, ALU_W_LONG, 1'b0, 32'd0, 32'd1, '0);
        run_cmd(2, ALU_ADD, ALU_W_LONG, 1'b0, 32'd0, 32'd0, '0);
        for (int r = 0; r < 4; r++) begin
            run_cmd(1, ALU_ADC, ALU_W_BYTE, 1'b0, r ? xorshift32() : '0, r ? xorshift32() : '0, '0);
            run_cmd(2, ALU_ADC, ALU_W_BYTE, 1'b0, r ? xorshift32() : '0, r ? xorshift32() : '0, '0);
        end
    endtask

    task automatic bus_errors();
        logic [31:0] got;
        logic [1:0]  resp;
        int          lat;
        axil_write(5'h18, 32'h1234_5678, resp, lat);
        check_resp("unmapped write bresp", resp, SLVERR);
        axil_read(5'h1C, got, resp);
        check_resp("unmapped read rresp", resp, SLVERR);
        axil_write(`ALU_REG_RESULT, 32'hDEAD_BEEF, resp, lat);
        check_resp("result write bresp", resp, OKAY);
        axil_read(`ALU_REG_RESULT, got, resp);
        check_result("result after write", got, last_result);
        axil_write(`ALU_REG_STATUS, 32'hFFFF_FFFF, resp, lat);
        check_resp("status write bresp", resp, OKAY);
        run_cmd(3, ALU_XOR, ALU_W_LONG, 1'b1, 32'h5A5A_0F0F, '0, 32'hFFFF_00FF);
    endtask

    initial begin
        rst       = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        errors    = 0;
        checks    = 0;
        timeouts  = 0;
        rng_state = 32'he2ce_5928;
        last_result = '0;
        for (int l = 0; l < NL; l++) begin
            ref_result[l] = '0;
            ref_flags[l]  = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        rst = 1'b0;
        @(posedge clk);
        #(DRIVE_DLY);

        after_reset();
        arith_ops();
        logic_ops();
        ext_and_scan();
        lane_chains();
        bus_errors();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- hw/alu_cluster_top.sv
/*
 * ALU cluster top
 * AXI4-Lite register block, dispatcher, lane array and collector
 */
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_cluster_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ALU_ADDR_W-1:0]    s_awaddr,
    input  logic                      s_awvalid,
    output logic                      s_awready,
    input  logic [`ALU_DATA_W-1:0]    s_wdata,
    input  logic [`ALU_DATA_W/8-1:0]  s_wstrb,
    input  logic                      s_wvalid,
    output logic                      s_wready,
    output logic [1:0]                s_bresp,
    output logic                      s_bvalid,
    input  logic                      s_bready,
    input  logic [`ALU_ADDR_W-1:0]    s_araddr,
    input  logic                      s_arvalid,
    output logic                      s_arready,
    output logic [`ALU_DATA_W-1:0]    s_rdata,
    output logic [1:0]                s_rresp,
    output logic                      s_rvalid,
    input  logic                      s_rready
);
    import alu_pkg::*;

    // names match the sub-block ports, connected by .*
    logic                      issue;
    logic                      done;
    logic [`ALU_DATA_W-1:0]    cmd_word, op0, op1, imm;
    logic [`ALU_DATA_W-1:0]    src, dst, result;
    logic [1:0]                lane_id;
    logic [`ALU_NUM_LANES-1:0] lane_issue;
    logic [`ALU_NUM_LANES-1:0] lane_done;
    logic [`ALU_DATA_W-1:0]    lane_result [`ALU_NUM_LANES];
    alu_op_e                   op;
    alu_width_e                width;
    alu_flags_t                flags;
    alu_flags_t                lane_flags [`ALU_NUM_LANES];

    axil_regs regs_i (.*);

    cmd_dispatch dispatch_i (.*);

    for (genvar i = 0; i < `ALU_NUM_LANES; i++) begin : g_lane
        alu_lane lane_i (
            .clk    (clk),
            .rst    (rst),
            .start  (lane_issue[i]),
            .op     (op),
            .width  (width),
            .src    (src),
            .dst    (dst),
            .done   (lane_done[i]),
            .result (lane_result[i]),
            .flags  (lane_flags[i])
        );
    end

    result_collect collect_i (.*);

endmodule

//--- hw/alu_config.svh
/*
 * ALU cluster build configuration
 * lane count, datapath and bus widths, register map offsets
 */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// lane field in the command word is 2 bits, so 1..4 lanes
`define ALU_NUM_LANES   4

`define ALU_DATA_W      32
`define ALU_ADDR_W      5

// register byte offsets
`define ALU_REG_OP0     5'h00
`define ALU_REG_OP1     5'h04
`define ALU_REG_IMM     5'h08
`define ALU_REG_CMD     5'h0C
`define ALU_REG_RESULT  5'h10  // read only
`define ALU_REG_STATUS  5'h14  // read only

`endif

//--- hw/alu_lane.sv
/*
 * ALU lane
 * one execution context with its own result and flag register,
 * width aware add/sub chains, logic ops, extends and bit scans
 */
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_lane (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  alu_pkg::alu_op_e       op,
    input  alu_pkg::alu_width_e    width,
    input  logic [`ALU_DATA_W-1:0] src,
    input  logic [`ALU_DATA_W-1:0] dst,
    output logic                   done,
    output logic [`ALU_DATA_W-1:0] result,
    output alu_pkg::alu_flags_t    flags
);
    import alu_pkg::*;

    logic                   is_byte, is_word, is_sub, upd;
    logic                   cin, hc, top_a, top_b, top_r, c_w, par;
    logic [2:0]             cc;
    logic [3:0]             bs_lo, bs_hi;
    logic [15:0]            mirr;
    logic [`ALU_DATA_W-1:0] mask, a, b, sum, raw, res_w;
    alu_flags_t             nx;

    // top bit of x at the selected width
    function automatic logic msb(input logic [`ALU_DATA_W-1:0] x,
                                 input logic byte_w, input logic word_w);
        return byte_w ? x[7] : word_w ? x[15] : x[`ALU_DATA_W-1];
    endfunction

    always_comb begin
        is_byte = width == ALU_W_BYTE;
        is_word = width == ALU_W_WORD;
        mask    = is_byte ? 32'h0000_00FF : is_word ? 32'h0000_FFFF : 32'hFFFF_FFFF;
        is_sub  = op inside {ALU_SUB, ALU_SBC, ALU_CP, ALU_NEG};

        // subtraction runs as a + ~b + ~borrow
        a   = (op == ALU_NEG) ? '0 : dst;
        b   = (op == ALU_NEG) ? dst : src;
        b   = is_sub ? ~b : b;
        cin = (op == ALU_ADC) ? flags.c : (op == ALU_SBC) ? ~flags.c : is_sub;

        {hc,    sum[3:0]}   = {1'b0, a[3:0]}   + {1'b0, b[3:0]}   + {4'd0, cin};
        {cc[0], sum[7:4]}   = {1'b0, a[7:4]}   + {1'b0, b[7:4]}   + {4'd0, hc};
        {cc[1], sum[15:8]}  = {1'b0, a[15:8]}  + {1'b0, b[15:8]}  + {8'd0, cc[0]};
        {cc[2], sum[31:16]} = {1'b0, a[31:16]} + {1'b0, b[31:16]} + {16'd0, cc[1]};
        c_w   = is_byte ? cc[0] : is_word ? cc[1] : cc[2];
        top_a = msb(a, is_byte, is_word);
        top_b = msb(b, is_byte, is_word);  // already inverted for sub

        // bit scans and mirror over the low half
        bs_lo = '0;
        bs_hi = '0;
        for (int i = 15; i >= 0; i--) begin
            if (src[i])
                bs_lo = 4'(i);  // last hit is the lowest set bit
        end
        for (int i = 0; i < 16; i++) begin
            if (src[i])
                bs_hi = 4'(i);
            mirr[i] = dst[15-i];
        end

        upd = 1'b1;
        case (op)
            ALU_MOVE: raw = src;
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP, ALU_NEG: raw = sum;
            ALU_AND:  raw = dst & src;
            ALU_OR:   raw = dst | src;
            ALU_XOR:  raw = dst ^ src;
            ALU_CPL:  raw = ~src;
            ALU_EXTZ: raw = is_word ? {24'd0, dst[7:0]} : {16'd0, dst[15:0]};
            ALU_EXTS: raw = is_word ? {{24{dst[7]}}, dst[7:0]} : {{16{dst[15]}}, dst[15:0]};
            ALU_MIRR: raw = {16'd0, mirr};
            ALU_BS1F: raw = {28'd0, bs_lo};
            ALU_BS1B: raw = {28'd0, bs_hi};
            default: begin  // CCF and unknown codes
                raw = result;
                upd = 1'b0;
            end
        endcase
        if (op == ALU_CP)
            upd = 1'b0;  // compare only touches flags

        res_w = raw & mask;
        top_r = msb(res_w, is_byte, is_word);
        par   = is_byte ? ~^res_w[7:0] : ~^res_w[15:0];

        nx = flags;
        case (op)
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP, ALU_NEG: begin
                nx.s = top_r;
                nx.z = res_w == '0;
                nx.h = hc ^ is_sub;  // borrow is the inverted carry
                nx.v = (top_a == top_b) && (top_r != top_a);
                nx.n = is_sub;
                nx.c = c_w ^ is_sub;
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                nx.s = top_r;
                nx.z = res_w == '0;
                nx.h = op == ALU_AND;
                nx.v = par;
                nx.n = 1'b0;
                nx.c = 1'b0;
            end
            ALU_CPL: begin
                nx.h = 1'b1;
                nx.n = 1'b1;
            end
            ALU_CCF: begin
                nx.c = ~flags.c;
                nx.n = 1'b0;
            end
            ALU_BS1F, ALU_BS1B: nx.v = src[15:0] == '0;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done   <= 1'b0;
            result <= '0;
            flags  <= '0;
        end else begin
            done <= start;
            if (start) begin
                if (upd)
                    result <= res_w;
                flags <= nx;  // private to this lane
            end
        end
    end

endmodule

//--- hw/alu_pkg.sv
/*
 * ALU cluster shared types
 * operation codes, operand widths and the flag register layout
 */
package alu_pkg;

    typedef enum logic [4:0] {
        ALU_MOVE = 5'd0,
        ALU_ADD  = 5'd1,
        ALU_ADC  = 5'd2,
        ALU_SUB  = 5'd3,
        ALU_SBC  = 5'd4,
        ALU_CP   = 5'd5,
        ALU_NEG  = 5'd6,
        ALU_AND  = 5'd7,
        ALU_OR   = 5'd8,
        ALU_XOR  = 5'd9,
        ALU_CPL  = 5'd10,
        ALU_CCF  = 5'd11,
        ALU_EXTZ = 5'd12,
        ALU_EXTS = 5'd13,
        ALU_MIRR = 5'd14,
        ALU_BS1F = 5'd15,
        ALU_BS1B = 5'd16
    } alu_op_e;  // remaining codes are no-ops

    typedef enum logic [1:0] {
        ALU_W_BYTE = 2'd0,
        ALU_W_WORD = 2'd1,
        ALU_W_LONG = 2'd2
    } alu_width_e;  // code 3 behaves as long

    typedef struct packed {
        logic s;     // sign
        logic z;     // zero
        logic rsv1;
        logic h;     // half carry
        logic rsv0;
        logic v;     // overflow or parity
        logic n;     // negative, set by subtraction
        logic c;     // carry
    } alu_flags_t;

endpackage

//--- hw/axil_regs.sv
/*
 * AXI4-Lite register block
 * operand and command registers, result and status readback;
 * a command write holds its B response until the result is stored
 */
`timescale 1ns/100ps
`include "alu_config.svh"

module axil_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ALU_ADDR_W-1:0]    s_awaddr,
    input  logic                      s_awvalid,
    output logic                      s_awready,
    input  logic [`ALU_DATA_W-1:0]    s_wdata,
    input  logic [`ALU_DATA_W/8-1:0]  s_wstrb,
    input  logic                      s_wvalid,
    output logic                      s_wready,
    output logic [1:0]                s_bresp,
    output logic                      s_bvalid,
    input  logic                      s_bready,
    input  logic [`ALU_ADDR_W-1:0]    s_araddr,
    input  logic                      s_arvalid,
    output logic                      s_arready,
    output logic [`ALU_DATA_W-1:0]    s_rdata,
    output logic [1:0]                s_rresp,
    output logic                      s_rvalid,
    input  logic                      s_rready,
    output logic                      issue,
    output logic [`ALU_DATA_W-1:0]    cmd_word,
    output logic [`ALU_DATA_W-1:0]    op0,
    output logic [`ALU_DATA_W-1:0]    op1,
    output logic [`ALU_DATA_W-1:0]    imm,
    input  logic                      done,
    input  logic [`ALU_DATA_W-1:0]    result,
    input  alu_pkg::alu_flags_t       flags,
    input  logic [1:0]                lane_id
);
    import alu_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                   wr_hs, rd_hs, busy, wr_ok, rd_ok;
    logic [`ALU_DATA_W-1:0] cmd_q, result_q, rd_data;
    alu_flags_t             flags_q;
    logic [1:0]             lane_q;

    // byte lane merge for strobed writes
    function automatic logic [`ALU_DATA_W-1:0] merge(input logic [`ALU_DATA_W-1:0] old_v,
                                                     input logic [`ALU_DATA_W-1:0] new_v,
                                                     input logic [`ALU_DATA_W/8-1:0] strb);
        logic [`ALU_DATA_W-1:0] r;
        r = old_v;
        for (int i = 0; i < `ALU_DATA_W/8; i++) begin
            if (strb[i])
                r[8*i +: 8] = new_v[8*i +: 8];
        end
        return r;
    endfunction

    // AW and W are taken together, never while a command or response is pending
    assign wr_hs     = s_awvalid & s_wvalid & ~busy & ~s_bvalid;
    assign s_awready = wr_hs;
    assign s_wready  = wr_hs;
    assign issue     = wr_hs && s_awaddr == `ALU_REG_CMD;
    assign cmd_word  = merge(cmd_q, s_wdata, s_wstrb);
    assign wr_ok     = s_awaddr inside {`ALU_REG_OP0, `ALU_REG_OP1, `ALU_REG_IMM,
                                        `ALU_REG_CMD, `ALU_REG_RESULT, `ALU_REG_STATUS};

    assign s_arready = ~s_rvalid;
    assign rd_hs     = s_arvalid & s_arready;

    always_comb begin
        rd_ok = 1'b1;
        case (s_araddr)
            `ALU_REG_OP0:    rd_data = op0;
            `ALU_REG_OP1:    rd_data = op1;
            `ALU_REG_IMM:    rd_data = imm;
            `ALU_REG_CMD:    rd_data = cmd_q;
            `ALU_REG_RESULT: rd_data = result_q;
            `ALU_REG_STATUS: rd_data = {14'd0, lane_q, 8'd0, flags_q};
            default: begin
                rd_data = '0;
                rd_ok   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_bvalid <= 1'b0;
            s_bresp  <= RESP_OKAY;
            s_rvalid <= 1'b0;
            s_rresp  <= RESP_OKAY;
            busy     <= 1'b0;
            result_q <= '0;
            flags_q  <= '0;
            lane_q   <= '0;
        end else begin
            if (s_bvalid && s_bready)
                s_bvalid <= 1'b0;
            if (wr_hs) begin
                if (issue) begin
                    busy <= 1'b1;  // response waits for done
                end else begin
                    s_bvalid <= 1'b1;
                    s_bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                end
            end
            if (done) begin
                result_q <= result;
                flags_q  <= flags;
                lane_q   <= lane_id;
                if (busy) begin
                    busy     <= 1'b0;
                    s_bvalid <= 1'b1;
                    s_bresp  <= RESP_OKAY;
                end
            end

            if (s_rvalid && s_rready)
                s_rvalid <= 1'b0;
            if (rd_hs) begin
                s_rvalid <= 1'b1;
                s_rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            case (s_awaddr)
                `ALU_REG_OP0: op0   <= merge(op0, s_wdata, s_wstrb);
                `ALU_REG_OP1: op1   <= merge(op1, s_wdata, s_wstrb);
                `ALU_REG_IMM: imm   <= merge(imm, s_wdata, s_wstrb);
                `ALU_REG_CMD: cmd_q <= cmd_word;
                default: ;  // RESULT and STATUS are read only
            endcase
        end
        if (rd_hs)
            s_rdata <= rd_data;
    end

endmodule

//--- hw/cmd_dispatch.sv
/*
 * Command dispatcher
 * decodes the command word and issues it to one lane
 */
`timescale 1ns/100ps
`include "alu_config.svh"

module cmd_dispatch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue,
    input  logic [`ALU_DATA_W-1:0]    cmd_word,
    input  logic [`ALU_DATA_W-1:0]    op0,
    input  logic [`ALU_DATA_W-1:0]    op1,
    input  logic [`ALU_DATA_W-1:0]    imm,
    output logic [`ALU_NUM_LANES-1:0] lane_issue,
    output alu_pkg::alu_op_e          op,
    output alu_pkg::alu_width_e       width,
    output logic [`ALU_DATA_W-1:0]    src,
    output logic [`ALU_DATA_W-1:0]    dst
);
    import alu_pkg::*;

    localparam int NL = `ALU_NUM_LANES;

    int lane_sel;

    // lane field wraps onto the lanes present
    always_comb lane_sel = int'(cmd_word[17:16]) % NL;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            lane_issue <= '0;
        else
            lane_issue <= issue ? NL'(1) << lane_sel : '0;  // one cycle strobe
    end

    // broadcast to all lanes, only the strobed one takes it
    always_ff @(posedge clk) begin
        if (issue) begin
            op    <= alu_op_e'(cmd_word[4:0]);
            width <= alu_width_e'(cmd_word[9:8]);
            src   <= cmd_word[12] ? imm : op1;
            dst   <= op0;
        end
    end

endmodule

//--- hw/result_collect.sv
/*
 * Result collector
 * picks the lane that finished and registers its result,
 * flags and lane number
 */
`timescale 1ns/100ps
`include "alu_config.svh"

module result_collect (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ALU_NUM_LANES-1:0] lane_done,
    input  logic [`ALU_DATA_W-1:0]    lane_result [`ALU_NUM_LANES],
    input  alu_pkg::alu_flags_t       lane_flags [`ALU_NUM_LANES],
    output logic                      done,
    output logic [`ALU_DATA_W-1:0]    result,
    output alu_pkg::alu_flags_t       flags,
    output logic [1:0]                lane_id
);
    import alu_pkg::*;

    logic [1:0] sel;

    // only one command in flight, so at most one lane is done
    always_comb begin
        sel = '0;
        for (int i = 0; i < `ALU_NUM_LANES; i++) begin
            if (lane_done[i])
                sel = 2'(i);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done    <= 1'b0;
            result  <= '0;
            flags   <= '0;
            lane_id <= '0;
        end else begin
            done <= |lane_done;
            if (|lane_done) begin
                result  <= lane_result[sel];
                flags   <= lane_flags[sel];
                lane_id <= sel;
            end
        end
    end

endmodule

//--- project.f
+incdir+hw
hw/alu_pkg.sv
hw/alu_lane.sv
hw/cmd_dispatch.sv
hw/result_collect.sv
hw/axil_regs.sv
hw/alu_cluster_top.sv
bench/tb_alu_cluster.sv
